// File: Makefile
VERILATOR  = verilator
TOP        = tb_cpu
RTL_TOP    = cpu
FILELIST   = cpu.f
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpu.f
+incdir+include
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/branch_unit.sv
src/hazard_forward.sv
src/cpu.sv
verif/tb_cpu.sv

// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ---------------------------------------------------------------------------
// Opcode encodings, instr[15:12]
// ---------------------------------------------------------------------------
`define CPU_OP_ADD 4'h0
`define CPU_OP_SUB 4'h1
`define CPU_OP_XOR 4'h2
`define CPU_OP_AND 4'h3
`define CPU_OP_SLL 4'h4 // Shifts take a 4-bit immediate
`define CPU_OP_SRA 4'h5
`define CPU_OP_ROR 4'h6
`define CPU_OP_OR  4'h7
`define CPU_OP_LW  4'h8 // Memory group, bit 3 set
`define CPU_OP_SW  4'h9
`define CPU_OP_LHB 4'hA
`define CPU_OP_LLB 4'hB
`define CPU_OP_B   4'hC // ccc + 9-bit word offset
`define CPU_OP_BR  4'hD // ccc + target register
`define CPU_OP_PCS 4'hE
`define CPU_OP_HLT 4'hF

// Core constants
`define CPU_RESET_PC 16'h0000
`define CPU_NUM_REGS 16

`endif

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t   result,
	output cpu_pkg::flags_t  flags,
	output cpu_pkg::flags_t  flags_wr
);

	cpu_pkg::word_t sum;
	cpu_pkg::word_t diff;
	logic [31:0] rot; // Doubled word for the rotate
	logic ovf;

	assign sum  = a + b; // 16-bit wrap
	assign diff = a - b;
	assign rot  = {a, a} >> b[3:0];

	always_comb begin
		result = a | b;
		ovf = 1'b0;
		flags_wr = '{zero: 1'b1, overflow: 1'b0, negative: 1'b0}; // Logic and shifts
		case ({1'b0, op})
			cpu_pkg::ADD: begin
				result = sum;
				ovf = (a[15] == b[15]) && (sum[15] != a[15]); // Like signs, sign flips
				flags_wr = '{zero: 1'b1, overflow: 1'b1, negative: 1'b1};
			end
			cpu_pkg::SUB: begin
				result = diff;
				ovf = (a[15] != b[15]) && (diff[15] != a[15]);
				flags_wr = '{zero: 1'b1, overflow: 1'b1, negative: 1'b1};
			end
			cpu_pkg::XOR:
				result = a ^ b;
			cpu_pkg::AND:
				result = a & b;
			cpu_pkg::SLL:
				result = a << b[3:0];
			cpu_pkg::SRA:
				result = cpu_pkg::word_t'($signed(a) >>> b[3:0]); // Sign fill
			cpu_pkg::ROR:
				result = rot[15:0];
			cpu_pkg::OR:
				result = a | b;
			default:
				result = a | b;
		endcase
	end

	// Flag values, the write enables decide which ones land
	assign flags.zero     = (result == '0);
	assign flags.overflow = ovf;
	assign flags.negative = result[15];

endmodule

`default_nettype wire

// File: src/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            flush, // Execute slot holds a bubble
	input  cpu_pkg::flags_t flags_new,
	input  cpu_pkg::flags_t flags_wr,
	input  logic            is_branch_imm,
	input  logic            is_branch_reg,
	input  cpu_pkg::cond_t  cond,
	input  logic [8:0]      offset,
	input  cpu_pkg::word_t  pc_next,
	input  cpu_pkg::word_t  reg_target,
	output logic            branch_taken,
	output cpu_pkg::word_t  branch_target
);

	cpu_pkg::flags_t flags_q;
	logic cond_met;

	// Per-flag update, bubbles leave the flags alone
	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= '0;
		end else if (!flush) begin
			if (flags_wr.zero)
				flags_q.zero <= flags_new.zero;
			if (flags_wr.overflow)
				flags_q.overflow <= flags_new.overflow;
			if (flags_wr.negative)
				flags_q.negative <= flags_new.negative;
		end
	end

	always_comb begin
		case (cond)
			3'd0: cond_met = ~flags_q.zero; // NE
			3'd1: cond_met = flags_q.zero; // EQ
			3'd2: cond_met = ~flags_q.zero & ~flags_q.negative; // GT
			3'd3: cond_met = flags_q.negative; // LT
			3'd4: cond_met = flags_q.zero | ~flags_q.negative; // GE
			3'd5: cond_met = flags_q.zero | flags_q.negative; // LE
			3'd6: cond_met = flags_q.overflow;
			default: cond_met = 1'b1; // Always
		endcase
	end

	assign branch_taken  = ~flush & cond_met & (is_branch_imm | is_branch_reg);
	assign branch_target = is_branch_reg ? reg_target :
		pc_next + {{6{offset[8]}}, offset, 1'b0}; // Word offset from PC+2

endmodule

`default_nettype wire

// File: src/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu (
	input  logic              clk,
	input  logic              rst,
	output cpu_pkg::word_t    imem_addr,
	input  cpu_pkg::word_t    imem_data,
	output logic              dmem_en,
	output logic              dmem_wr,
	output cpu_pkg::word_t    dmem_addr,
	output cpu_pkg::word_t    dmem_wdata,
	input  cpu_pkg::word_t    dmem_rdata,
	output logic              hlt,
	output cpu_pkg::word_t    pc_out,
	output cpu_pkg::retire_t  retire
);

	cpu_pkg::word_t pc_q, pc_d, pc_plus2;
	cpu_pkg::if_id_t if_id_q, if_id_d;
	cpu_pkg::id_ex_t id_ex_q, id_ex_d;
	cpu_pkg::ex_mem_t ex_mem_q, ex_mem_d;
	cpu_pkg::mem_wb_t mem_wb_q, mem_wb_d;

	logic stall, squash, ex_halt, halt_seen;
	logic branch_taken;
	cpu_pkg::word_t branch_target;
	cpu_pkg::fwd_sel_t fwd_a, fwd_b;

	cpu_pkg::opcode_t id_op, ex_op;
	cpu_pkg::reg_sel_t id_rs_sel, id_rt_sel;
	cpu_pkg::word_t id_rs_data, id_rt_data;

	cpu_pkg::word_t ex_a, ex_rt, alu_b, alu_result, ex_result, ex_mem_addr;
	cpu_pkg::flags_t alu_flags, alu_flags_wr, ex_flags_wr;
	logic ex_is_alu, ex_shift;

	cpu_pkg::word_t mem_data; // Value leaving the memory stage
	logic wb_we;

	// Operand mux shared by both execute sources
	function automatic cpu_pkg::word_t fwd_mux(cpu_pkg::fwd_sel_t sel, cpu_pkg::word_t rf_val,
		cpu_pkg::word_t mem_val, cpu_pkg::word_t wb_val);
		case (sel)
			cpu_pkg::FROM_MEM: return mem_val;
			cpu_pkg::FROM_WB: return wb_val;
			default: return rf_val;
		endcase
	endfunction

	// -----------------------------------------------------------------------
	// Fetch
	// -----------------------------------------------------------------------
	assign imem_addr = pc_q;
	assign pc_plus2  = pc_q + 16'd2;
	assign if_id_d   = '{valid: 1'b1, pc_next: pc_plus2, instr: imem_data};

	// Taken HLT in execute kills the two younger slots too
	assign ex_halt   = id_ex_q.valid & id_ex_q.halt;
	assign halt_seen = (ex_mem_q.valid & ex_mem_q.halt) | (mem_wb_q.valid & mem_wb_q.halt) | hlt;
	assign squash    = branch_taken | ex_halt | halt_seen;

	always_comb begin
		if (branch_taken)
			pc_d = branch_target;
		else if (ex_halt)
			pc_d = id_ex_q.pc_next; // Park on the word after HLT
		else if (halt_seen || stall)
			pc_d = pc_q;
		else
			pc_d = pc_plus2;
	end

	// -----------------------------------------------------------------------
	// Decode
	// -----------------------------------------------------------------------
	assign id_op = cpu_pkg::opcode_t'(if_id_q.instr[15:12]);

	// SW, LHB, LLB read rd first; LW, SW read base second
	assign id_rs_sel = (id_op inside {cpu_pkg::SW, cpu_pkg::LHB, cpu_pkg::LLB}) ?
		if_id_q.instr[11:8] : if_id_q.instr[7:4];
	assign id_rt_sel = (id_op inside {cpu_pkg::LW, cpu_pkg::SW}) ?
		if_id_q.instr[7:4] : if_id_q.instr[3:0];

	register_file i_register_file (
		.clk     (clk),
		.rst     (rst),
		.rs_sel  (id_rs_sel),
		.rt_sel  (id_rt_sel),
		.wr_en   (wb_we),
		.wr_sel  (mem_wb_q.rd_sel),
		.wr_data (mem_wb_q.data),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data)
	);

	always_comb begin
		id_ex_d.valid     = if_id_q.valid & ~stall & ~squash; // Bubble on stall
		id_ex_d.pc_next   = if_id_q.pc_next;
		id_ex_d.instr     = if_id_q.instr;
		id_ex_d.rs_sel    = id_rs_sel;
		id_ex_d.rt_sel    = id_rt_sel;
		id_ex_d.rs_data   = id_rs_data;
		id_ex_d.rt_data   = id_rt_data;
		id_ex_d.rd_sel    = if_id_q.instr[11:8];
		id_ex_d.reg_write = ~if_id_q.instr[15] |
			(id_op inside {cpu_pkg::LW, cpu_pkg::LHB, cpu_pkg::LLB, cpu_pkg::PCS});
		id_ex_d.mem_read  = (id_op == cpu_pkg::LW);
		id_ex_d.mem_write = (id_op == cpu_pkg::SW);
		id_ex_d.halt      = (id_op == cpu_pkg::HLT);
	end

	// -----------------------------------------------------------------------
	// Execute
	// -----------------------------------------------------------------------
	assign ex_op     = cpu_pkg::opcode_t'(id_ex_q.instr[15:12]);
	assign ex_is_alu = ~id_ex_q.instr[15];
	assign ex_shift  = ex_op inside {cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR};

	always_comb begin
		ex_a  = fwd_mux(fwd_a, id_ex_q.rs_data, mem_data, mem_wb_q.data);
		ex_rt = fwd_mux(fwd_b, id_ex_q.rt_data, mem_data, mem_wb_q.data);
	end

	assign alu_b = ex_shift ? {12'b0, id_ex_q.instr[3:0]} : ex_rt; // Shift amount

	alu i_alu (
		.a        (ex_a),
		.b        (alu_b),
		.op       (id_ex_q.instr[14:12]),
		.result   (alu_result),
		.flags    (alu_flags),
		.flags_wr (alu_flags_wr)
	);

	assign ex_flags_wr = ex_is_alu ? alu_flags_wr : '0;

	branch_unit i_branch_unit (
		.clk           (clk),
		.rst           (rst),
		.flush         (~id_ex_q.valid),
		.flags_new     (alu_flags),
		.flags_wr      (ex_flags_wr),
		.is_branch_imm (ex_op == cpu_pkg::B),
		.is_branch_reg (ex_op == cpu_pkg::BR),
		.cond          (id_ex_q.instr[11:9]),
		.offset        (id_ex_q.instr[8:0]),
		.pc_next       (id_ex_q.pc_next),
		.reg_target    (ex_a),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	always_comb begin
		if (ex_is_alu)
			ex_result = alu_result;
		else if (ex_op == cpu_pkg::LHB)
			ex_result = {id_ex_q.instr[7:0], ex_a[7:0]};
		else if (ex_op == cpu_pkg::LLB)
			ex_result = {ex_a[15:8], id_ex_q.instr[7:0]};
		else
			ex_result = id_ex_q.pc_next; // PCS
	end

	// Even base plus scaled signed offset
	assign ex_mem_addr = (ex_rt & 16'hFFFE) + {{11{id_ex_q.instr[3]}}, id_ex_q.instr[3:0], 1'b0};

	assign ex_mem_d = '{valid: id_ex_q.valid, result: ex_result, mem_addr: ex_mem_addr,
		store_data: ex_a, rd_sel: id_ex_q.rd_sel, reg_write: id_ex_q.reg_write,
		mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write, halt: id_ex_q.halt};

	// -----------------------------------------------------------------------
	// Memory and writeback
	// -----------------------------------------------------------------------
	assign dmem_en    = ex_mem_q.valid & (ex_mem_q.mem_read | ex_mem_q.mem_write);
	assign dmem_wr    = ex_mem_q.valid & ex_mem_q.mem_write;
	assign dmem_addr  = ex_mem_q.mem_addr;
	assign dmem_wdata = ex_mem_q.store_data;
	assign mem_data   = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.result;

	assign mem_wb_d = '{valid: ex_mem_q.valid, rd_sel: ex_mem_q.rd_sel,
		reg_write: ex_mem_q.reg_write, data: mem_data, halt: ex_mem_q.halt};

	assign wb_we  = mem_wb_q.valid & mem_wb_q.reg_write;
	assign retire = '{valid: wb_we, rd_sel: mem_wb_q.rd_sel, data: mem_wb_q.data};
	assign pc_out = pc_q;

	hazard_forward i_hazard_forward (
		.clk           (clk),
		.rst           (rst),
		.id_rs_sel     (id_rs_sel),
		.id_rt_sel     (id_rt_sel),
		.id_valid      (if_id_q.valid),
		.ex_mem_read   (id_ex_q.valid & id_ex_q.mem_read),
		.ex_rd_sel     (id_ex_q.rd_sel),
		.ex_rs_sel     (id_ex_q.rs_sel),
		.ex_rt_sel     (id_ex_q.rt_sel),
		.mem_reg_write (ex_mem_q.valid & ex_mem_q.reg_write),
		.mem_rd_sel    (ex_mem_q.rd_sel),
		.wb_reg_write  (wb_we),
		.wb_rd_sel     (mem_wb_q.rd_sel),
		.wb_halt       (mem_wb_q.valid & mem_wb_q.halt),
		.stall         (stall),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.hlt           (hlt)
	);

	// PC and pipeline registers
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q     <= `CPU_RESET_PC;
			if_id_q  <= '0;
			id_ex_q  <= '0;
			ex_mem_q <= '0;
			mem_wb_q <= '0;
		end else begin
			pc_q <= pc_d;
			if (squash)
				if_id_q.valid <= 1'b0; // Younger fetch dropped
			else if (!stall)
				if_id_q <= if_id_d;
			id_ex_q  <= id_ex_d;
			ex_mem_q <= ex_mem_d;
			mem_wb_q <= mem_wb_d;
		end
	end

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [15:0] word_t; // Data, address or instruction
	typedef logic [3:0] reg_sel_t;
	typedef logic [2:0] alu_op_t; // Low bits of an ALU opcode
	typedef logic [2:0] cond_t; // Branch condition code

	typedef enum logic [3:0] {
		ADD = `CPU_OP_ADD,
		SUB = `CPU_OP_SUB,
		XOR = `CPU_OP_XOR,
		AND = `CPU_OP_AND,
		SLL = `CPU_OP_SLL,
		SRA = `CPU_OP_SRA,
		ROR = `CPU_OP_ROR,
		OR  = `CPU_OP_OR,
		LW  = `CPU_OP_LW,
		SW  = `CPU_OP_SW,
		LHB = `CPU_OP_LHB,
		LLB = `CPU_OP_LLB,
		B   = `CPU_OP_B,
		BR  = `CPU_OP_BR,
		PCS = `CPU_OP_PCS,
		HLT = `CPU_OP_HLT
	} opcode_t;

	typedef struct packed {
		logic zero;
		logic overflow;
		logic negative;
	} flags_t;

	// Forwarding source for an execute operand
	typedef enum logic [1:0] {
		NONE     = 2'd0,
		FROM_MEM = 2'd1,
		FROM_WB  = 2'd2
	} fwd_sel_t;

	// -----------------------------------------------------------------------
	// Pipeline registers
	// -----------------------------------------------------------------------
	typedef struct packed {
		logic valid;
		word_t pc_next;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc_next; // PCS result and branch base
		word_t instr;
		reg_sel_t rs_sel;
		reg_sel_t rt_sel;
		word_t rs_data;
		word_t rt_data;
		reg_sel_t rd_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic halt;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		word_t result;
		word_t mem_addr;
		word_t store_data;
		reg_sel_t rd_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic halt;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		reg_sel_t rd_sel;
		logic reg_write;
		word_t data;
		logic halt;
	} mem_wb_t;

	// One register write leaving writeback
	typedef struct packed {
		logic valid;
		reg_sel_t rd_sel;
		word_t data;
	} retire_t;

endpackage

`default_nettype wire

// File: src/hazard_forward.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_forward (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::reg_sel_t   id_rs_sel,
	input  cpu_pkg::reg_sel_t   id_rt_sel,
	input  logic                id_valid,
	input  logic                ex_mem_read, // Valid load in execute
	input  cpu_pkg::reg_sel_t   ex_rd_sel,
	input  cpu_pkg::reg_sel_t   ex_rs_sel,
	input  cpu_pkg::reg_sel_t   ex_rt_sel,
	input  logic                mem_reg_write,
	input  cpu_pkg::reg_sel_t   mem_rd_sel,
	input  logic                wb_reg_write,
	input  cpu_pkg::reg_sel_t   wb_rd_sel,
	input  logic                wb_halt,
	output logic                stall,
	output cpu_pkg::fwd_sel_t   fwd_a,
	output cpu_pkg::fwd_sel_t   fwd_b,
	output logic                hlt
);

	logic load_hit;

	// Youngest producer wins, R0 never forwarded
	function automatic cpu_pkg::fwd_sel_t pick_src(cpu_pkg::reg_sel_t src);
		if (src == '0)
			return cpu_pkg::NONE;
		if (mem_reg_write && mem_rd_sel == src)
			return cpu_pkg::FROM_MEM;
		if (wb_reg_write && wb_rd_sel == src)
			return cpu_pkg::FROM_WB;
		return cpu_pkg::NONE;
	endfunction

	always_comb begin
		fwd_a = pick_src(ex_rs_sel);
		fwd_b = pick_src(ex_rt_sel);
	end

	// Load result only exists after memory, one bubble
	assign load_hit = (ex_rd_sel != '0) &&
		(ex_rd_sel == id_rs_sel || ex_rd_sel == id_rt_sel);
	assign stall = id_valid & ex_mem_read & load_hit;

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst)
			hlt <= 1'b0;
		else if (wb_halt)
			hlt <= 1'b1;
	end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module register_file (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::reg_sel_t rs_sel,
	input  cpu_pkg::reg_sel_t rt_sel,
	input  logic              wr_en,
	input  cpu_pkg::reg_sel_t wr_sel,
	input  cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    rs_data,
	output cpu_pkg::word_t    rt_data
);

	cpu_pkg::word_t regs [`CPU_NUM_REGS];

	// R0 reads zero, writeback bypasses the array
	function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_sel_t sel);
		if (sel == '0)
			return '0;
		if (wr_en && wr_sel == sel)
			return wr_data; // Same-cycle write-through
		return regs[sel];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_sel != '0) begin
			regs[wr_sel] <= wr_data; // Writes to R0 dropped
		end
	end

	always_comb begin
		rs_data = read_port(rs_sel);
		rt_data = read_port(rt_sel);
	end

endmodule

`default_nettype wire

// File: verif/cpu_trace.txt
# I addr word = program image | R reg data = expected retire in order
# S addr data = expected store in order | H pc = expected PC once halted
I 0000 B134  # LLB R1, 0x34
I 0002 A112  # LHB R1, 0x12, R1 from memory stage
I 0004 B2FF  # LLB R2, 0xFF
I 0006 A27F  # LHB R2, 0x7F
I 0008 B301  # LLB R3, 0x01
I 000A 0423  # ADD R4, R2, R3 signed overflow
I 000C 1543  # SUB R5, R4, R3 signed overflow
I 000E 2612  # XOR R6, R1, R2
I 0010 3716  # AND R7, R1, R6 zero result
I 0012 7813  # OR R8, R1, R3
I 0014 4914  # SLL R9, R1, 4
I 0016 5A43  # SRA R10, R4, 3
I 0018 6B14  # ROR R11, R1, 4
I 001A 0011  # ADD R0, R1, R1
I 001C 0C01  # ADD R12, R0, R1 R0 stays zero
I 001E BD41  # LLB R13, 0x41 odd base
I 0020 91D2  # SW R1, [R13+2]
I 0022 94DF  # SW R4, [R13-1]
I 0024 8ED2  # LW R14, [R13+2]
I 0026 0FE2  # ADD R15, R14, R2 load-use
I 0028 85D3  # LW R5, [R13+3] fill word
I 002A 95D4  # SW R5, [R13+4] load-use on data
I 002C C202  # B EQ, not taken
I 002E CC02  # B OV, taken to 0034
I 0030 B6EE  # flushed
I 0032 B7EE  # flushed
I 0034 1633  # SUB R6, R3, R3
I 0036 C001  # B NE, not taken
I 0038 C601  # B LT, not taken
I 003A CA02  # B LE, taken to 0040
I 003C B8EE  # flushed
I 003E B9EE  # flushed
I 0040 EA00  # PCS R10
I 0042 BB50  # LLB R11, 0x50
I 0044 AB00  # LHB R11, 0x00
I 0046 DEB0  # BR always, R11
I 0048 BCEE  # flushed
I 004A BDEE  # flushed
I 0050 2C33  # XOR R12, R3, R3
I 0052 D0B0  # BR NE, not taken
I 0054 C401  # B GT, not taken
I 0056 C802  # B GE, taken to 005C
I 0058 B1EE  # flushed
I 005A B2EE  # flushed
I 005C ED00  # PCS R13
I 005E 9D05  # SW R13, [R0+5]
I 0060 F000  # HLT
I 0062 B1EE  # squashed by halt
I 0064 B2EE  # squashed by halt
R 1 0034
R 1 1234
R 2 00FF
R 2 7FFF
R 3 0001
R 4 8000
R 5 7FFF
R 6 6DCB
R 7 0000
R 8 1235
R 9 2340
R A F000
R B 4123
R 0 2468
R C 1234
R D 0041
R E 1234
R F 9233
R 5 23DC
R 6 0000
R A 0042
R B 4150
R B 0050
R C 0000
R D 005E
S 0044 1234
S 003E 8000
S 0048 23DC
S 000A 005E
H 0062

// File: verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam string TRACE_FILE = "verif/cpu_trace.txt";
	localparam int MEM_WORDS = 256;
	localparam int QUIET_CYCLES = 8; // Idle window after hlt

	// One expected data memory write
	typedef struct packed {
		cpu_pkg::word_t addr;
		cpu_pkg::word_t data;
	} store_t;

	logic clk;
	logic rst;
	cpu_pkg::word_t imem_addr;
	cpu_pkg::word_t imem_data;
	logic dmem_en;
	logic dmem_wr;
	cpu_pkg::word_t dmem_addr;
	cpu_pkg::word_t dmem_wdata;
	cpu_pkg::word_t dmem_rdata;
	logic hlt;
	cpu_pkg::word_t pc_out;
	cpu_pkg::retire_t retire;

	cpu_pkg::word_t imem [MEM_WORDS];
	cpu_pkg::word_t dmem [MEM_WORDS];
	cpu_pkg::retire_t exp_retire [$]; // In program order
	store_t exp_store [$];
	cpu_pkg::word_t halt_pc;

	int n_prog;
	int cycle;
	int limit;
	int retire_errs;
	int store_errs;
	int other_errs;
	bit trace_ok;

	cpu i_cpu (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_en    (dmem_en),
		.dmem_wr    (dmem_wr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.hlt        (hlt),
		.pc_out     (pc_out),
		.retire     (retire)
	);

	// Word arrays at byte addresses
	assign imem_data  = imem[imem_addr[8:1]];
	assign dmem_rdata = dmem_en ? dmem[dmem_addr[8:1]] : 16'h0000; // Data only while enabled

	always #2 clk = ~clk; // 4 ns period

	// ------------------------------------------------------------------------
	// Memory fill and trace loading
	// ------------------------------------------------------------------------
	task automatic fill_memories();
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = {8'hF0, 8'(i)}; // HLT everywhere off the program
			dmem[i] = {8'(i), ~8'(i)};
		end
	endtask

	// Drops the rest of a line with any comment
	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 32'd10 && c != -1)
			c = $fgetc(fd);
	endtask

	task automatic load_trace(output bit ok);
		int fd;
		int n;
		logic [7:0] tag;
		cpu_pkg::word_t a;
		cpu_pkg::word_t d;
		cpu_pkg::retire_t r;
		store_t s;
		ok = 1'b0;
		n_prog = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd != 0) begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"I": begin
						n = $fscanf(fd, "%h %h", a, d);
						assert (n == 2) else begin
							other_errs++;
							$display("** Error: malformed program line in trace file");
						end
						imem[a[8:1]] = d;
						n_prog++;
					end
					"R": begin
						n = $fscanf(fd, "%h %h", a, d);
						assert (n == 2) else begin
							other_errs++;
							$display("** Error: malformed retire line in trace file");
						end
						r = '{valid: 1'b1, rd_sel: a[3:0], data: d};
						exp_retire.push_back(r);
					end
					"S": begin
						n = $fscanf(fd, "%h %h", a, d);
						assert (n == 2) else begin
							other_errs++;
							$display("** Error: malformed store line in trace file");
						end
						s = '{addr: a, data: d};
						exp_store.push_back(s);
					end
					"H": begin
						n = $fscanf(fd, "%h", halt_pc);
						assert (n == 1) else begin
							other_errs++;
							$display("** Error: malformed halt line in trace file");
						end
					end
					default: ; // Comment line
				endcase
				skip_line(fd);
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// ------------------------------------------------------------------------
	// Checkers
	// ------------------------------------------------------------------------
	task automatic check_retire();
		cpu_pkg::retire_t want;
		assert (!hlt) else begin
			retire_errs++;
			$display("** Error at %0t: register R%0d written while halted", $time, retire.rd_sel);
		end
		assert (exp_retire.size() > 0) else begin
			retire_errs++;
			$display("** Error at %0t: unexpected retire of R%0d = %h", $time,
				retire.rd_sel, retire.data);
		end
		if (exp_retire.size() > 0) begin
			want = exp_retire.pop_front();
			assert (retire.rd_sel == want.rd_sel) else begin
				retire_errs++;
				$display("** Error at %0t: retire.rd_sel = %0d, expected %0d", $time,
					retire.rd_sel, want.rd_sel);
			end
			assert (retire.data == want.data) else begin
				retire_errs++;
				$display("** Error at %0t: retire.data = %h, expected %h", $time,
					retire.data, want.data);
			end
		end
	endtask

	// Compares one store and updates the data memory model
	task automatic check_store();
		store_t want;
		assert (dmem_en) else begin
			store_errs++;
			$display("** Error at %0t: dmem_wr raised without dmem_en", $time);
		end
		assert (exp_store.size() > 0) else begin
			store_errs++;
			$display("** Error at %0t: unexpected store of %h to %h", $time,
				dmem_wdata, dmem_addr);
		end
		if (exp_store.size() > 0) begin
			want = exp_store.pop_front();
			assert (dmem_addr == want.addr) else begin
				store_errs++;
				$display("** Error at %0t: dmem_addr = %h, expected %h", $time,
					dmem_addr, want.addr);
			end
			assert (dmem_wdata == want.data) else begin
				store_errs++;
				$display("** Error at %0t: dmem_wdata = %h, expected %h", $time,
					dmem_wdata, want.data);
			end
		end
		dmem[dmem_addr[8:1]] = dmem_wdata;
	endtask

	task automatic check_halt();
		assert (pc_out == halt_pc) else begin
			other_errs++;
			$display("** Error at %0t: pc_out = %h, expected %h", $time, pc_out, halt_pc);
		end
		assert (exp_retire.size() == 0) else begin
			other_errs++;
			$display("** Error at %0t: halted with %0d register writes still missing",
				$time, exp_retire.size());
		end
	endtask

	task automatic check_end();
		assert (hlt) else begin
			other_errs++;
			$display("** Error at %0t: hlt dropped before the end of the run", $time);
		end
		assert (pc_out == halt_pc) else begin
			other_errs++;
			$display("** Error at %0t: pc_out = %h, expected %h", $time, pc_out, halt_pc);
		end
		assert (exp_store.size() == 0) else begin
			other_errs++;
			$display("** Error at %0t: %0d expected stores never happened", $time,
				exp_store.size());
		end
	endtask

	// Retire and store checks on the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (retire.valid)
				check_retire();
			if (dmem_wr)
				check_store();
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (limit > 0 && cycle > limit) begin
			$display("** Error at %0t: timeout, no halt within %0d cycles", $time, limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cycle = 0;
		limit = 0;
		retire_errs = 0;
		store_errs = 0;
		other_errs = 0;
		fill_memories();
		load_trace(trace_ok);
		if (!trace_ok) begin
			$display("** Error: trace file %s could not be opened", TRACE_FILE);
			$display("Result: FAILED");
			$finish;
		end else begin
			limit = 8 * n_prog + 100;
			repeat (4) @(posedge clk);
			#0.5 rst = 1'b0;
			// Wait for hlt one step past each rising edge
			while (!hlt) begin
				@(posedge clk);
				#1;
			end
			check_halt();
			repeat (QUIET_CYCLES) @(posedge clk);
			#1;
			check_end();
			$display("Errors: %0d retire, %0d store, %0d other",
				retire_errs, store_errs, other_errs);
			if (retire_errs + store_errs + other_errs == 0)
				$display("Result: PASSED");
			else
				$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire
